// File: id_stage.f
isa_pkg.sv
pipe_pkg.sv
regfile.sv
id_stage_reg.sv
inst_decoder.sv
operand_bypass.sv
id_stage.sv
id_stage_checker.sv
id_stage_assert.sv
tb_id_stage.sv

// File: id_stage.sv
`timescale 1ns/10ps

module id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    input  logic      es_allow_in,
    input  fwd_src_t  es_fwd,
    input  fwd_src_t  ms_fwd,
    input  wb_t       wb,
    output logic      ds_allow_in,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es_bus,
    output br_t       br
);

    logic                  ds_valid;
    fs_to_ds_t             ds_bus;
    logic [reg_addr_w-1:0] raddr1, raddr2;
    logic                  reads_r1, reads_r2;
    ds_ctrl_t              ctrl;
    br_kind_t              bk;
    logic [xlen-1:0]       br_offs, jirl_offs, rdata1, rdata2, rj_value, rkd_value, diff;
    logic                  need_block, br_cancel, cout;
    logic                  rj_eq_rkd, signed_lt, unsigned_lt, cond_taken, pc_rel;

    id_stage_reg u_stage_reg (.clk(clk), .reset(reset), .flush(flush), .br_cancel(br_cancel),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus),
        .ds_allow_in(ds_allow_in), .ds_valid(ds_valid), .ds_bus(ds_bus));

    inst_decoder u_decoder (.inst(ds_bus.inst), .raddr1(raddr1), .raddr2(raddr2),
        .reads_r1(reads_r1), .reads_r2(reads_r2), .ctrl(ctrl), .branch_kind(bk),
        .br_offs(br_offs), .jirl_offs(jirl_offs));

    regfile u_regfile (.clk(clk), .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1),
        .rdata2(rdata2), .wr(wb));

    operand_bypass u_bypass (.ds_valid(ds_valid), .flush(flush), .raddr1(raddr1),
        .raddr2(raddr2), .reads_r1(reads_r1), .reads_r2(reads_r2), .rdata1(rdata1),
        .rdata2(rdata2), .es_fwd(es_fwd), .ms_fwd(ms_fwd), .wb(wb), .rj_value(rj_value),
        .rkd_value(rkd_value), .need_block(need_block));

    // rj - rkd as rj + ~rkd + 1, carry out means rj >= rkd unsigned
    assign {cout, diff} = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;
    assign rj_eq_rkd    = rj_value == rkd_value;
    assign unsigned_lt  = ~cout;
    // sign bits differ, rj negative; else sign of the difference
    assign signed_lt    = (rj_value[31] & ~rkd_value[31])
                          | (~(rj_value[31] ^ rkd_value[31]) & diff[31]);

    assign cond_taken = (bk.beq & rj_eq_rkd) | (bk.bne & ~rj_eq_rkd)
                        | (bk.blt & signed_lt) | (bk.bge & ~signed_lt)
                        | (bk.bltu & unsigned_lt) | (bk.bgeu & ~unsigned_lt);
    assign pc_rel     = bk.beq | bk.bne | bk.blt | bk.bge | bk.bltu | bk.bgeu | bk.b | bk.bl;

    assign br.taken  = (cond_taken | bk.b | bk.bl | bk.jirl) & ds_valid & ~need_block;
    // hold fetch while a pc-relative branch waits on a load
    assign br.stall  = pc_rel & need_block;
    assign br.target = bk.jirl ? (rj_value + jirl_offs) : (ds_bus.pc + br_offs);
    // cancel only as the branch itself leaves, so a held branch is not lost
    assign br_cancel = br.taken & es_allow_in;

    // ready_go is just the load-use check
    assign ds_allow_in    = ~ds_valid | (~need_block & es_allow_in);
    assign ds_to_es_valid = ds_valid & ~need_block;

    assign ds_to_es_bus.pc        = ds_bus.pc;
    assign ds_to_es_bus.rj_value  = rj_value;
    assign ds_to_es_bus.rkd_value = rkd_value;
    assign ds_to_es_bus.ctrl      = ctrl;

endmodule

// File: id_stage_assert.sv
`timescale 1ns/10ps

module id_stage_assert
(
    input logic clk,
    input logic reset,
    input logic flush,
    input logic es_allow_in,
    input logic ds_valid,
    input logic ds_allow_in,
    input logic ds_to_es_valid
);

    // an offered item that execute refuses stays in decode
    held_under_backpressure: assert property (@(posedge clk) disable iff (reset)
        ds_to_es_valid && !es_allow_in && !flush |=> ds_valid)
        else $error("decode dropped an item while execute was stalled");

    // reset or flush leaves decode empty
    empty_after_clear: assert property (@(posedge clk) (reset || flush) |=> !ds_valid)
        else $error("decode holds an item after reset or flush");

    open_after_reset: assert property (@(posedge clk) reset |=> ds_allow_in)
        else $error("ds_allow_in low after reset");

endmodule

bind id_stage id_stage_assert u_assert (.clk(clk), .reset(reset), .flush(flush),
    .es_allow_in(es_allow_in), .ds_valid(ds_valid), .ds_allow_in(ds_allow_in),
    .ds_to_es_valid(ds_to_es_valid));

// File: id_stage_checker.sv
`timescale 1ns/10ps

module id_stage_checker
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      flush,
    input logic      fs_to_ds_valid,
    input fs_to_ds_t fs_to_ds_bus,
    input logic      es_allow_in,
    input fwd_src_t  es_fwd,
    input fwd_src_t  ms_fwd,
    input wb_t       wb,
    input logic      ds_allow_in,
    input logic      ds_to_es_valid,
    input ds_to_es_t ds_to_es_bus,
    input br_t       br
);

    int err_count = 0;
    int check_count = 0;

    // items accepted from fetch, front one sits in decode
    fs_to_ds_t        pending [$];
    logic [xlen-1:0]  mirror [0:31];
    fs_to_ds_t        item;
    ds_ctrl_t         c;
    logic [4:0]       a1, a2;
    logic             u1, u2, blk, taken;
    int               kind;
    logic [xlen-1:0]  v1, v2, target, off16, off26;

    task automatic expect_val(input string what, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp)
        begin
            err_count++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // kind: 1..6 beq bne blt bge bltu bgeu, 7 b, 8 bl, 9 jirl
    task automatic model_decode(input inst_word_t w, output ds_ctrl_t d, output logic [4:0] r1,
                                output logic [4:0] r2, output logic p1, output logic p2,
                                output int k);
        logic [5:0]  m;
        logic [3:0]  g;
        logic [4:0]  f;
        logic        known;
        logic [31:0] si12;
        m = w[31:26];
        g = w[25:22];
        f = w[19:15];
        si12 = {{20{w[21]}}, w[21:10]};
        d = '0;
        d.dest = w[4:0];
        r1 = w[9:5];
        r2 = w[14:10];
        p1 = 1'b1;
        p2 = 1'b0;
        k = 0;
        known = 1'b1;
        if (w[31:20] == 12'h001)
        begin
            p2 = 1'b1;
            case (f)
                5'h00: d.alu_op.add = 1'b1;
                5'h02: d.alu_op.sub = 1'b1;
                5'h04: d.alu_op.slt = 1'b1;
                5'h05: d.alu_op.sltu = 1'b1;
                5'h08: d.alu_op.nor_ = 1'b1;
                5'h09: d.alu_op.and_ = 1'b1;
                5'h0a: d.alu_op.or_ = 1'b1;
                5'h0b: d.alu_op.xor_ = 1'b1;
                5'h0e: d.alu_op.sll = 1'b1;
                5'h0f: d.alu_op.srl = 1'b1;
                5'h10: d.alu_op.sra = 1'b1;
                default: known = 1'b0;
            endcase
        end
        else if (w[31:20] == 12'h004)
        begin
            d.src2_is_imm = 1'b1;
            d.imm = {27'b0, w[14:10]};
            case (f)
                5'h01: d.alu_op.sll = 1'b1;
                5'h09: d.alu_op.srl = 1'b1;
                5'h11: d.alu_op.sra = 1'b1;
                default: known = 1'b0;
            endcase
        end
        else if (m == 6'h00 && g[3])
        begin
            d.src2_is_imm = 1'b1;
            // logic ops zero extend
            d.imm = g[2] ? {20'b0, w[21:10]} : si12;
            case (g)
                4'h8: d.alu_op.slt = 1'b1;
                4'h9: d.alu_op.sltu = 1'b1;
                4'ha: d.alu_op.add = 1'b1;
                4'hd: d.alu_op.and_ = 1'b1;
                4'he: d.alu_op.or_ = 1'b1;
                4'hf: d.alu_op.xor_ = 1'b1;
                default: known = 1'b0;
            endcase
        end
        else if (m == 6'h0a && (g == 4'h2 || g == 4'h6))
        begin
            d.alu_op.add = 1'b1;
            d.src2_is_imm = 1'b1;
            d.imm = si12;
            d.res_from_mem = (g == 4'h2);
            d.mem_we = (g == 4'h6);
            p2 = (g == 4'h6);
            r2 = w[4:0];
        end
        else if ((m == 6'h05 || m == 6'h07) && !w[25])
        begin
            d.imm = {w[24:5], 12'b0};
            d.src2_is_imm = 1'b1;
            d.alu_op.lui = (m == 6'h05);
            d.alu_op.add = (m == 6'h07);
            d.src1_is_pc = (m == 6'h07);
            p1 = 1'b0;
        end
        else if (m >= 6'h16 && m <= 6'h1b)
        begin
            k = int'(m) - 'h15;
            p2 = 1'b1;
            r2 = w[4:0];
        end
        else if (m == 6'h13 || m == 6'h14 || m == 6'h15)
        begin
            k = (m == 6'h13) ? 9 : (m == 6'h14) ? 7 : 8;
            p1 = (m == 6'h13);
            if (m != 6'h14)
            begin
                // link address pc + 4
                d.alu_op.add = 1'b1;
                d.src1_is_pc = 1'b1;
                d.src2_is_imm = 1'b1;
                d.imm = 32'd4;
            end
            if (m == 6'h15)
                d.dest = 5'd1;
        end
        else
            known = 1'b0;
        d.gr_we = known && !d.mem_we && (k == 0 || k == 8 || k == 9);
        if (!known)
        begin
            d = '0;
            d.dest = w[4:0];
            d.ine = 1'b1;
            p1 = 1'b0;
            p2 = 1'b0;
            k = 0;
        end
    endtask

    // youngest stage first, then the wb write, then the mirror
    function automatic logic [xlen-1:0] operand_model(input logic [4:0] a);
        if (a == 5'd0)
            return '0;
        if (es_fwd.valid && es_fwd.we && es_fwd.dest == a)
            return es_fwd.wdata;
        if (ms_fwd.valid && ms_fwd.we && ms_fwd.dest == a)
            return ms_fwd.wdata;
        if (wb.we && wb.waddr == a)
            return wb.wdata;
        return mirror[a];
    endfunction

    function automatic logic load_hit(input logic [4:0] a, input logic used);
        logic es_ld;
        logic ms_ld;
        es_ld = es_fwd.valid && es_fwd.we && es_fwd.dest == a && es_fwd.is_load;
        ms_ld = ms_fwd.valid && ms_fwd.we && ms_fwd.dest == a && ms_fwd.is_load
                && !ms_fwd.result_ready;
        return used && a != 5'd0 && (es_ld || ms_ld);
    endfunction

    always @(posedge clk)
    begin
        if (reset || flush)
            pending.delete();
        else
        begin
            blk = 1'b0;
            taken = 1'b0;
            kind = 0;
            if (pending.size() > 0)
            begin
                item = pending[0];
                model_decode(item.inst, c, a1, a2, u1, u2, kind);
                v1 = operand_model(a1);
                v2 = operand_model(a2);
                blk = load_hit(a1, u1) || load_hit(a2, u2);
                off16 = {{14{item.inst[25]}}, item.inst[25:10], 2'b00};
                off26 = {{4{item.inst[9]}}, item.inst[9:0], item.inst[25:10], 2'b00};
                case (kind)
                    1: taken = (v1 == v2);
                    2: taken = (v1 != v2);
                    3: taken = ($signed(v1) < $signed(v2));
                    4: taken = ($signed(v1) >= $signed(v2));
                    5: taken = (v1 < v2);
                    6: taken = (v1 >= v2);
                    7, 8, 9: taken = 1'b1;
                    default: taken = 1'b0;
                endcase
                taken = taken && !blk;
                target = (kind == 9) ? v1 + off16 : item.pc + ((kind >= 7) ? off26 : off16);
            end
            expect_val("ds_to_es_valid", ds_to_es_valid, pending.size() > 0 && !blk);
            expect_val("ds_allow_in", ds_allow_in, pending.size() == 0 || (!blk && es_allow_in));
            expect_val("br.taken", br.taken, taken);
            expect_val("br.stall", br.stall, blk && kind >= 1 && kind <= 8);
            if (taken)
                expect_val("br.target", br.target, target);
            if (ds_to_es_valid && es_allow_in && pending.size() > 0)
            begin
                expect_val("pc", ds_to_es_bus.pc, item.pc);
                expect_val("ctrl", ds_to_es_bus.ctrl, c);
                if (u1)
                    expect_val("rj_value", ds_to_es_bus.rj_value, v1);
                if (u2)
                    expect_val("rkd_value", ds_to_es_bus.rkd_value, v2);
                void'(pending.pop_front());
            end
            // the item behind a leaving taken branch is dropped
            if (fs_to_ds_valid && ds_allow_in && !(br.taken && es_allow_in))
                pending.push_back(fs_to_ds_bus);
        end
        if (wb.we && wb.waddr != 5'd0)
            mirror[wb.waddr] = wb.wdata;
    end

endmodule

// File: id_stage_reg.sv
`timescale 1ns/10ps

module id_stage_reg
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      flush,
    input  logic      br_cancel,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    input  logic      ds_allow_in,
    output logic      ds_valid,
    output fs_to_ds_t ds_bus
);

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            ds_valid <= 1'b0;
            ds_bus   <= '0;
        end
        else
        begin
            // taken branch drops the wrong-path item behind it
            if (br_cancel)
                ds_valid <= 1'b0;
            else if (ds_allow_in)
                ds_valid <= fs_to_ds_valid;
            // payload only moves on a real handoff
            if (fs_to_ds_valid && ds_allow_in)
                ds_bus <= fs_to_ds_bus;
        end
    end

endmodule

// File: inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  inst_word_t            inst,
    output logic [reg_addr_w-1:0] raddr1,
    output logic [reg_addr_w-1:0] raddr2,
    output logic                  reads_r1,
    output logic                  reads_r2,
    output ds_ctrl_t              ctrl,
    output br_kind_t              branch_kind,
    output logic [xlen-1:0]       br_offs,
    output logic [xlen-1:0]       jirl_offs
);

    logic is_3r;
    logic is_shimm;
    logic add_w, sub_w, slt, sltu, nor_w, and_w, or_w, xor_w, sll_w, srl_w, sra_w;
    logic slli_w, srli_w, srai_w;
    logic addi_w, slti, sltiu, andi, ori, xori, ld_w, st_w;
    logic lu12i_w, pcaddu12i, jirl, b, bl, beq, bne, blt, bge, bltu, bgeu;
    logic cond_br, reg3_op, known, need_si20, need_ui5, need_si12, need_ui12;
    logic [9:0]  grp_i12;
    logic [5:0]  major;
    logic [19:0] i20;
    logic [25:0] i26;

    // register view
    assign is_3r    = {inst.fmt_r.op_31_26, inst.fmt_r.op_25_22, inst.fmt_r.op_21_20} == op_grp_3r;
    assign is_shimm = {inst.fmt_r.op_31_26, inst.fmt_r.op_25_22, inst.fmt_r.op_21_20}
                      == op_grp_shimm;
    assign add_w  = is_3r && inst.fmt_r.op_19_15 == op_add_w;
    assign sub_w  = is_3r && inst.fmt_r.op_19_15 == op_sub_w;
    assign slt    = is_3r && inst.fmt_r.op_19_15 == op_slt;
    assign sltu   = is_3r && inst.fmt_r.op_19_15 == op_sltu;
    assign nor_w  = is_3r && inst.fmt_r.op_19_15 == op_nor;
    assign and_w  = is_3r && inst.fmt_r.op_19_15 == op_and;
    assign or_w   = is_3r && inst.fmt_r.op_19_15 == op_or;
    assign xor_w  = is_3r && inst.fmt_r.op_19_15 == op_xor;
    assign sll_w  = is_3r && inst.fmt_r.op_19_15 == op_sll_w;
    assign srl_w  = is_3r && inst.fmt_r.op_19_15 == op_srl_w;
    assign sra_w  = is_3r && inst.fmt_r.op_19_15 == op_sra_w;
    assign slli_w = is_shimm && inst.fmt_r.op_19_15 == op_slli_w;
    assign srli_w = is_shimm && inst.fmt_r.op_19_15 == op_srli_w;
    assign srai_w = is_shimm && inst.fmt_r.op_19_15 == op_srai_w;

    // 12-bit immediate view
    assign grp_i12 = {inst.fmt_i12.op_31_26, inst.fmt_i12.op_25_22};
    assign addi_w  = grp_i12 == op_addi_w;
    assign slti    = grp_i12 == op_slti;
    assign sltiu   = grp_i12 == op_sltiu;
    assign andi    = grp_i12 == op_andi;
    assign ori     = grp_i12 == op_ori;
    assign xori    = grp_i12 == op_xori;
    assign ld_w    = grp_i12 == op_ld_w;
    assign st_w    = grp_i12 == op_st_w;

    // long immediate view, bit 25 must be clear for the si20 forms
    assign major     = inst.fmt_il.op_31_26;
    assign lu12i_w   = major == op_lu12i_w && !inst.fmt_il.i16[15];
    assign pcaddu12i = major == op_pcaddu12i && !inst.fmt_il.i16[15];
    assign jirl      = major == op_jirl;
    assign b         = major == op_b;
    assign bl        = major == op_bl;
    assign beq       = major == op_beq;
    assign bne       = major == op_bne;
    assign blt       = major == op_blt;
    assign bge       = major == op_bge;
    assign bltu      = major == op_bltu;
    assign bgeu      = major == op_bgeu;

    assign cond_br   = beq | bne | blt | bge | bltu | bgeu;
    assign reg3_op   = is_3r & (add_w | sub_w | slt | sltu | nor_w | and_w | or_w | xor_w
                       | sll_w | srl_w | sra_w);
    assign known     = reg3_op | slli_w | srli_w | srai_w | addi_w | slti | sltiu | andi | ori
                       | xori | ld_w | st_w | lu12i_w | pcaddu12i | jirl | b | bl | cond_br;
    assign need_ui5  = slli_w | srli_w | srai_w;
    assign need_si12 = addi_w | slti | sltiu | ld_w | st_w;
    assign need_ui12 = andi | ori | xori;
    assign need_si20 = lu12i_w | pcaddu12i;

    assign i20 = {inst.fmt_il.i16[14:0], inst.fmt_il.rj};
    assign i26 = {inst.fmt_il.rj, inst.fmt_il.rd, inst.fmt_il.i16};

    // word offsets, shifted left by two
    assign br_offs   = (b | bl) ? {{4{i26[25]}}, i26, 2'b00}
                                : {{14{inst.fmt_il.i16[15]}}, inst.fmt_il.i16, 2'b00};
    assign jirl_offs = {{14{inst.fmt_il.i16[15]}}, inst.fmt_il.i16, 2'b00};

    // stores and compares read rd on the second port
    assign raddr1   = inst.fmt_r.rj;
    assign raddr2   = (cond_br | st_w) ? inst.fmt_r.rd : inst.fmt_r.rk;
    assign reads_r1 = known & ~b & ~bl & ~lu12i_w & ~pcaddu12i;
    assign reads_r2 = reg3_op | st_w | cond_br;

    assign branch_kind = '{beq: beq, bne: bne, blt: blt, bge: bge, bltu: bltu, bgeu: bgeu,
                           b: b, bl: bl, jirl: jirl};

    always_comb
    begin
        // link value pc+4 comes through the adder
        if (jirl | bl)
            ctrl.imm = 32'd4;
        else if (need_si20)
            ctrl.imm = {i20, 12'b0};
        else if (need_ui5)
            ctrl.imm = {27'b0, inst.fmt_r.rk};
        else if (need_si12)
            ctrl.imm = {{20{inst.fmt_i12.i12[11]}}, inst.fmt_i12.i12};
        else if (need_ui12)
            ctrl.imm = {20'b0, inst.fmt_i12.i12};
        else
            ctrl.imm = '0;
        // bl links into r1
        ctrl.dest         = bl ? 5'd1 : inst.fmt_r.rd;
        ctrl.gr_we        = known & ~st_w & ~cond_br & ~b;
        ctrl.mem_we       = st_w;
        ctrl.alu_op.add   = add_w | addi_w | ld_w | st_w | jirl | bl | pcaddu12i;
        ctrl.alu_op.sub   = sub_w;
        ctrl.alu_op.slt   = slt | slti;
        ctrl.alu_op.sltu  = sltu | sltiu;
        ctrl.alu_op.and_  = and_w | andi;
        ctrl.alu_op.nor_  = nor_w;
        ctrl.alu_op.or_   = or_w | ori;
        ctrl.alu_op.xor_  = xor_w | xori;
        ctrl.alu_op.sll   = sll_w | slli_w;
        ctrl.alu_op.srl   = srl_w | srli_w;
        ctrl.alu_op.sra   = sra_w | srai_w;
        ctrl.alu_op.lui   = lu12i_w;
        ctrl.src1_is_pc   = jirl | bl | pcaddu12i;
        ctrl.src2_is_imm  = need_ui5 | need_si12 | need_ui12 | need_si20 | jirl | bl;
        ctrl.res_from_mem = ld_w;
        ctrl.ine          = ~known;
    end

endmodule

// File: isa_pkg.sv
package isa_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // three-register group as {op_31_26, op_25_22, op_21_20}
    localparam logic [11:0] op_grp_3r    = 12'h001;
    // shift-by-ui5 group
    localparam logic [11:0] op_grp_shimm = 12'h004;

    // op_19_15 within the 3r group
    localparam logic [4:0] op_add_w  = 5'h00;
    localparam logic [4:0] op_sub_w  = 5'h02;
    localparam logic [4:0] op_slt    = 5'h04;
    localparam logic [4:0] op_sltu   = 5'h05;
    localparam logic [4:0] op_nor    = 5'h08;
    localparam logic [4:0] op_and    = 5'h09;
    localparam logic [4:0] op_or     = 5'h0a;
    localparam logic [4:0] op_xor    = 5'h0b;
    localparam logic [4:0] op_sll_w  = 5'h0e;
    localparam logic [4:0] op_srl_w  = 5'h0f;
    localparam logic [4:0] op_sra_w  = 5'h10;
    // op_19_15 within the shift group
    localparam logic [4:0] op_slli_w = 5'h01;
    localparam logic [4:0] op_srli_w = 5'h09;
    localparam logic [4:0] op_srai_w = 5'h11;

    // 12-bit immediate forms, {op_31_26, op_25_22}
    localparam logic [9:0] op_slti   = {6'h00, 4'h8};
    localparam logic [9:0] op_sltiu  = {6'h00, 4'h9};
    localparam logic [9:0] op_addi_w = {6'h00, 4'ha};
    localparam logic [9:0] op_andi   = {6'h00, 4'hd};
    localparam logic [9:0] op_ori    = {6'h00, 4'he};
    localparam logic [9:0] op_xori   = {6'h00, 4'hf};
    localparam logic [9:0] op_ld_w   = {6'h0a, 4'h2};
    localparam logic [9:0] op_st_w   = {6'h0a, 4'h6};

    // major opcode only
    localparam logic [5:0] op_lu12i_w   = 6'h05;
    localparam logic [5:0] op_pcaddu12i = 6'h07;
    localparam logic [5:0] op_jirl      = 6'h13;
    localparam logic [5:0] op_b         = 6'h14;
    localparam logic [5:0] op_bl        = 6'h15;
    localparam logic [5:0] op_beq       = 6'h16;
    localparam logic [5:0] op_bne       = 6'h17;
    localparam logic [5:0] op_blt       = 6'h18;
    localparam logic [5:0] op_bge       = 6'h19;
    localparam logic [5:0] op_bltu      = 6'h1a;
    localparam logic [5:0] op_bgeu      = 6'h1b;

    typedef struct packed {
        logic [5:0]            op_31_26;
        logic [3:0]            op_25_22;
        logic [1:0]            op_21_20;
        logic [4:0]            op_19_15;
        logic [reg_addr_w-1:0] rk;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } reg_fmt_t;

    typedef struct packed {
        logic [5:0]            op_31_26;
        logic [3:0]            op_25_22;
        logic [11:0]           i12;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } imm12_fmt_t;

    // i20 is {i16[14:0], rj}, i26 is {rj, rd, i16}
    typedef struct packed {
        logic [5:0]            op_31_26;
        logic [15:0]           i16;
        logic [reg_addr_w-1:0] rj;
        logic [reg_addr_w-1:0] rd;
    } imm_long_fmt_t;

    typedef union packed {
        reg_fmt_t      fmt_r;
        imm12_fmt_t    fmt_i12;
        imm_long_fmt_t fmt_il;
    } inst_word_t;

    // one-hot alu select
    typedef struct packed {
        logic add;
        logic sub;
        logic slt;
        logic sltu;
        logic and_;
        logic nor_;
        logic or_;
        logic xor_;
        logic sll;
        logic srl;
        logic sra;
        logic lui;
    } alu_op_t;

    // which branch sits in decode
    typedef struct packed {
        logic beq;
        logic bne;
        logic blt;
        logic bge;
        logic bltu;
        logic bgeu;
        logic b;
        logic bl;
        logic jirl;
    } br_kind_t;

endpackage

// File: operand_bypass.sv
`timescale 1ns/10ps

module operand_bypass
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  ds_valid,
    input  logic                  flush,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    input  logic                  reads_r1,
    input  logic                  reads_r2,
    input  logic [xlen-1:0]       rdata1,
    input  logic [xlen-1:0]       rdata2,
    input  fwd_src_t              es_fwd,
    input  fwd_src_t              ms_fwd,
    input  wb_t                   wb,
    output logic [xlen-1:0]       rj_value,
    output logic [xlen-1:0]       rkd_value,
    output logic                  need_block
);

    logic use1, use2;
    logic es_hit1, es_hit2, ms_hit1, ms_hit2, wb_hit1, wb_hit2;
    logic es_load_hit, ms_load_hit;

    function automatic logic fwd_hit(input fwd_src_t s, input logic [reg_addr_w-1:0] addr);
        return s.valid && s.we && s.dest == addr;
    endfunction

    // r0 never matches
    assign use1 = reads_r1 && raddr1 != '0;
    assign use2 = reads_r2 && raddr2 != '0;

    assign es_hit1 = use1 && fwd_hit(es_fwd, raddr1);
    assign es_hit2 = use2 && fwd_hit(es_fwd, raddr2);
    assign ms_hit1 = use1 && fwd_hit(ms_fwd, raddr1);
    assign ms_hit2 = use2 && fwd_hit(ms_fwd, raddr2);
    assign wb_hit1 = use1 && wb.we && wb.waddr == raddr1;
    assign wb_hit2 = use2 && wb.we && wb.waddr == raddr2;

    // youngest producer wins
    assign rj_value  = es_hit1 ? es_fwd.wdata : ms_hit1 ? ms_fwd.wdata : wb_hit1 ? wb.wdata : rdata1;
    assign rkd_value = es_hit2 ? es_fwd.wdata : ms_hit2 ? ms_fwd.wdata : wb_hit2 ? wb.wdata : rdata2;

    // load in execute never has data yet
    assign es_load_hit = es_fwd.is_load && (es_hit1 || es_hit2);
    // load in memory waits for its data
    assign ms_load_hit = ms_fwd.is_load && !ms_fwd.result_ready && (ms_hit1 || ms_hit2);

    assign need_block = ds_valid && !flush && (es_load_hit || ms_load_hit);

endmodule

// File: pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // fetch to decode
    typedef struct packed {
        logic [xlen-1:0] pc;
        inst_word_t      inst;
    } fs_to_ds_t;

    // decoded control, everything the decoder alone can produce
    typedef struct packed {
        logic [xlen-1:0]       imm;
        logic [reg_addr_w-1:0] dest;
        logic                  gr_we;
        logic                  mem_we;
        alu_op_t               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        logic                  res_from_mem;
        // instruction does not exist
        logic                  ine;
    } ds_ctrl_t;

    // decode to execute
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] rj_value;
        logic [xlen-1:0] rkd_value;
        ds_ctrl_t        ctrl;
    } ds_to_es_t;

    // what a later stage shows decode
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [reg_addr_w-1:0] dest;
        logic                  is_load;
        // load data is in wdata, always low from execute
        logic                  result_ready;
        logic [xlen-1:0]       wdata;
    } fwd_src_t;

    // register file write from writeback
    typedef struct packed {
        logic                  we;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
    } wb_t;

    // redirect to fetch
    typedef struct packed {
        logic            taken;
        logic            stall;
        logic [xlen-1:0] target;
    } br_t;

endpackage

// File: regfile.sv
`timescale 1ns/10ps

module regfile
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] raddr1,
    input  logic [reg_addr_w-1:0] raddr2,
    output logic [xlen-1:0]       rdata1,
    output logic [xlen-1:0]       rdata2,
    input  wb_t                   wr
);

    // slot 0 is never written
    logic [xlen-1:0] rf [0:(2**reg_addr_w)-1];

    always_ff @(posedge clk)
    begin
        if (wr.we && wr.waddr != '0)
        begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    // async read, new value seen the cycle after the write edge
    // r0 forced to zero
    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule

// File: run_sim.sh
#!/bin/sh
verilator --binary --assert --timing -Wno-fatal --top-module tb_id_stage -f id_stage.f \
    -o sim_id_stage > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_id_stage > sim.log 2>&1 || echo "simulator returned an error status"
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb_id_stage.sv
`timescale 1ns/10ps

module tb_id_stage
    import isa_pkg::*;
    import pipe_pkg::*;
;

    localparam int clk_period  = 20;
    localparam int n_cycles    = 3000;
    // at most two cycles per item, plus reset and register init
    localparam int cycle_limit = 2 * (n_cycles + 40) + 100;

    logic      clk = 1'b0;
    logic      reset;
    logic      flush;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds_bus;
    logic      es_allow_in;
    fwd_src_t  es_fwd;
    fwd_src_t  ms_fwd;
    wb_t       wb;
    logic      ds_allow_in;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    br_t       br;
    logic [31:0] lfsr = 32'hfa2f_f164;
    logic [31:0] pc = 32'h1c00_0000;

    logic [4:0] r3_ops [0:10] = '{op_add_w, op_sub_w, op_slt, op_sltu, op_nor, op_and, op_or,
                                  op_xor, op_sll_w, op_srl_w, op_sra_w};
    logic [4:0] sh_ops [0:2] = '{op_slli_w, op_srli_w, op_srai_w};
    logic [9:0] i12_ops [0:7] = '{op_slti, op_sltiu, op_addi_w, op_andi, op_ori, op_xori,
                                  op_ld_w, op_st_w};
    logic [5:0] long_ops [0:10] = '{op_lu12i_w, op_pcaddu12i, op_jirl, op_b, op_bl, op_beq,
                                    op_bne, op_blt, op_bge, op_bltu, op_bgeu};

    always #(clk_period / 2) clk = ~clk;

    id_stage id_stage_inst (.clk(clk), .reset(reset), .flush(flush),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus),
        .es_allow_in(es_allow_in), .es_fwd(es_fwd), .ms_fwd(ms_fwd), .wb(wb),
        .ds_allow_in(ds_allow_in), .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es_bus(ds_to_es_bus), .br(br));

    id_stage_checker checker_inst (.clk(clk), .reset(reset), .flush(flush),
        .fs_to_ds_valid(fs_to_ds_valid), .fs_to_ds_bus(fs_to_ds_bus),
        .es_allow_in(es_allow_in), .es_fwd(es_fwd), .ms_fwd(ms_fwd), .wb(wb),
        .ds_allow_in(ds_allow_in), .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es_bus(ds_to_es_bus), .br(br));

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic inst_word_t make_inst();
        inst_word_t w;
        logic [3:0] sel;
        w = take_bits(32);
        sel = 4'(take_bits(4));
        if (sel <= 4'd2)
        begin
            {w.fmt_r.op_31_26, w.fmt_r.op_25_22, w.fmt_r.op_21_20} = op_grp_3r;
            w.fmt_r.op_19_15 = r3_ops[take_bits(4) % 11];
        end
        else if (sel == 4'd3)
        begin
            {w.fmt_r.op_31_26, w.fmt_r.op_25_22, w.fmt_r.op_21_20} = op_grp_shimm;
            w.fmt_r.op_19_15 = sh_ops[take_bits(2) % 3];
        end
        else if (sel <= 4'd5)
            {w.fmt_i12.op_31_26, w.fmt_i12.op_25_22} = i12_ops[take_bits(3)];
        else if (sel <= 4'd13)
            w.fmt_il.op_31_26 = long_ops[take_bits(4) % 11];
        // low register numbers so hazards show up often; sel 15 stays a raw word
        if (sel != 4'd15)
        begin
            w.fmt_r.rj = 5'(take_bits(3));
            w.fmt_r.rd = 5'(take_bits(3));
            w.fmt_r.rk = 5'(take_bits(3));
        end
        return w;
    endfunction

    task automatic drive_cycle();
        fs_to_ds_valid       = take_bits(2) != 0;
        fs_to_ds_bus.pc      = pc;
        fs_to_ds_bus.inst    = make_inst();
        pc                   = pc + 32'd4;
        es_allow_in          = take_bits(2) != 0;
        es_fwd.valid         = take_bits(1) != 0;
        es_fwd.we            = take_bits(1) != 0;
        es_fwd.dest          = 5'(take_bits(3));
        es_fwd.is_load       = take_bits(1) != 0;
        es_fwd.result_ready  = 1'b0;
        es_fwd.wdata         = take_bits(32);
        ms_fwd.valid         = take_bits(1) != 0;
        ms_fwd.we            = take_bits(1) != 0;
        ms_fwd.dest          = 5'(take_bits(3));
        ms_fwd.is_load       = take_bits(1) != 0;
        ms_fwd.result_ready  = take_bits(1) != 0;
        ms_fwd.wdata         = take_bits(32);
        wb.we                = take_bits(1) != 0;
        wb.waddr             = 5'(take_bits(3));
        wb.wdata             = take_bits(32);
        // rare flush
        flush                = take_bits(6) == 0;
    endtask

    initial
    begin
        reset = 1'b1;
        flush = 1'b0;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        es_allow_in = 1'b0;
        es_fwd = '0;
        ms_fwd = '0;
        wb = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // give every register a known value
        for (int i = 1; i < 32; i++)
        begin
            wb.we = 1'b1;
            wb.waddr = 5'(i);
            wb.wdata = take_bits(32);
            @(negedge clk);
        end
        wb = '0;
        repeat (n_cycles)
        begin
            drive_cycle();
            @(negedge clk);
        end
        fs_to_ds_valid = 1'b0;
        flush = 1'b0;
        @(negedge clk);
        $display("checks %0d, errors %0d", checker_inst.check_count, checker_inst.err_count);
        if (checker_inst.err_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // watchdog
    initial
    begin
        #(cycle_limit * clk_period);
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("tests failed");
        $finish;
    end

endmodule
